//--- hw/trace_cfg_pkg.sv
// trace unit widths and sizes
package trace_cfg_pkg;

    //////////////////////////////////////////////////
    // payload widths
    //////////////////////////////////////////////////

    // instruction word as the cpu fetched it
    typedef logic [31:0] instr_t;

    // cycle stamp, wraps around silently
    typedef logic [15:0] cycle_t;

    // sequence id given at fetch acceptance, wraps
    typedef logic [7:0] seq_id_t;

    // records pushed in one capture window
    typedef logic [7:0] rec_count_t;

    //////////////////////////////////////////////////
    // default sizes
    //////////////////////////////////////////////////

    // stamp slots, must cover pipeline depth plus the longest stall run
    // five stages and three stall cycles in flight fit in eight
    localparam int DEF_STAMP_DEPTH = 8;

    // retire records held per capture window
    localparam int DEF_FIFO_DEPTH = 16;

endpackage

//--- hw/trace_state_pkg.sv
// trace unit state encodings
package trace_state_pkg;

    // pipeline stage index, also used as array index in the tracker
    typedef enum logic [2:0] {
        stg_fetch   = 3'd0,
        stg_decode  = 3'd1,
        stg_execute = 3'd2,
        stg_memory  = 3'd3,
        stg_wb      = 3'd4
    } stage_e;

    // capture window states
    // idle waits for start, capture pushes retires, readout drains
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_capture = 2'd1,
        st_readout = 2'd2
    } trace_state_e;

endpackage

//--- hw/cycle_counter.sv
// cycle stamp and record counter
`timescale 1ns/10ps

module cycle_counter
    import trace_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rec_push,
    input  logic       rec_clear,
    output cycle_t     now,
    output rec_count_t rec_count
);

    // free-running stamp
    // zero in the first cycle after reset, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            now <= '0;
        end else begin
            now <= now + 1'b1;
        end
    end

    // records pushed since the current window opened
    // clear and push never meet, push only happens in capture
    always_ff @(posedge clk) begin
        if (rst) begin
            rec_count <= '0;
        end else if (rec_clear) begin
            rec_count <= '0;
        end else if (rec_push) begin
            rec_count <= rec_count + 1'b1;
        end
    end

endmodule

//--- hw/stage_tracker.sv
// pipeline stage tracker
`timescale 1ns/10ps

module stage_tracker
    import trace_cfg_pkg::*;
    import trace_state_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    fetch,
    input  logic    stall,
    input  logic    flush,
    output logic    accept,
    output seq_id_t accept_id,
    output logic    retire,
    output seq_id_t retire_id
);

    localparam int NUM_STAGES = int'(stg_wb) + 1;

    // id handed to the next accepted fetch
    seq_id_t next_id;

    // one valid bit and one id per stage, indexed by stage_e
    logic [NUM_STAGES-1:0] valid_q;
    seq_id_t               id_q [NUM_STAGES];

    //////////////////////////////////////////////////
    // acceptance
    //////////////////////////////////////////////////

    // a fetch only counts when the front end is free to move
    assign accept    = fetch && !stall && !flush;
    assign accept_id = next_id;

    // flushed ids are burnt, the counter never steps back
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
        end else if (accept) begin
            next_id <= next_id + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            // back end always advances
            valid_q[stg_wb]     <= valid_q[stg_memory];
            valid_q[stg_memory] <= valid_q[stg_execute];

            // execute takes a bubble when decode holds or is flushed
            if (stall || flush) begin
                valid_q[stg_execute] <= 1'b0;
            end else begin
                valid_q[stg_execute] <= valid_q[stg_decode];
            end

            // flush wins over stall for the front end
            if (flush) begin
                valid_q[stg_fetch]  <= 1'b0;
                valid_q[stg_decode] <= 1'b0;
            end else if (!stall) begin
                valid_q[stg_decode] <= valid_q[stg_fetch];
                valid_q[stg_fetch]  <= accept;
            end
        end
    end

    //////////////////////////////////////////////////
    // stage ids
    //////////////////////////////////////////////////

    // ids follow the valid bits, their value only matters while valid
    always_ff @(posedge clk) begin
        id_q[stg_wb]      <= id_q[stg_memory];
        id_q[stg_memory]  <= id_q[stg_execute];
        id_q[stg_execute] <= id_q[stg_decode];
        // front end holds during stall
        if (!stall) begin
            id_q[stg_decode] <= id_q[stg_fetch];
            id_q[stg_fetch]  <= next_id;
        end
    end

    // write-back valid is the retire pulse
    assign retire    = valid_q[stg_wb];
    assign retire_id = id_q[stg_wb];

endmodule

//--- hw/stamp_store.sv
// fetch stamp store
`timescale 1ns/10ps

module stamp_store
    import trace_cfg_pkg::*;
#(
    parameter int STAMP_DEPTH = DEF_STAMP_DEPTH
) (
    input  logic    clk,
    input  logic    wr,
    input  seq_id_t wr_id,
    input  cycle_t  wr_cycle,
    input  instr_t  wr_instr,
    input  seq_id_t rd_id,
    output cycle_t  rd_cycle,
    output instr_t  rd_instr
);

    // slot index is the low part of the sequence id
    // depth is a power of two so the id wrap lines up with the slots
    localparam int ADDR_W = (STAMP_DEPTH > 1) ? $clog2(STAMP_DEPTH) : 1;

    cycle_t cycle_mem [STAMP_DEPTH];
    instr_t instr_mem [STAMP_DEPTH];

    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    assign wr_addr = wr_id[ADDR_W-1:0];
    assign rd_addr = rd_id[ADDR_W-1:0];

    // written on the acceptance edge with the stamp of that cycle
    always_ff @(posedge clk) begin
        if (wr) begin
            cycle_mem[wr_addr] <= wr_cycle;
            instr_mem[wr_addr] <= wr_instr;
        end
    end

    // read with the write-back id
    // slot stays untouched until the id comes round again
    assign rd_cycle = cycle_mem[rd_addr];
    assign rd_instr = instr_mem[rd_addr];

endmodule

//--- hw/trace_fifo.sv
// retire record buffer
`timescale 1ns/10ps

module trace_fifo
    import trace_cfg_pkg::*;
#(
    parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  seq_id_t push_id,
    input  instr_t  push_instr,
    input  cycle_t  push_fetch_cycle,
    input  cycle_t  push_retire_cycle,
    input  logic    pop,
    output logic    empty,
    output logic    full,
    output seq_id_t head_id,
    output instr_t  head_instr,
    output cycle_t  head_fetch_cycle,
    output cycle_t  head_retire_cycle
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // record fields, one array each
    seq_id_t id_mem     [FIFO_DEPTH];
    instr_t  instr_mem  [FIFO_DEPTH];
    cycle_t  fetch_mem  [FIFO_DEPTH];
    cycle_t  retire_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             is_full;
    logic             do_push;
    logic             do_pop;

    // pointer step with wrap at the last slot
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign is_full = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    // full also shows on the push that takes the last slot
    // so capture can close on that same edge
    assign full    = is_full || (push && count == CNT_W'(FIFO_DEPTH - 1));

    // push while full and pop while empty are dropped
    assign do_push = push && !is_full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            id_mem[wr_ptr]     <= push_id;
            instr_mem[wr_ptr]  <= push_instr;
            fetch_mem[wr_ptr]  <= push_fetch_cycle;
            retire_mem[wr_ptr] <= push_retire_cycle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // show-ahead head, valid whenever not empty
    assign head_id           = id_mem[rd_ptr];
    assign head_instr        = instr_mem[rd_ptr];
    assign head_fetch_cycle  = fetch_mem[rd_ptr];
    assign head_retire_cycle = retire_mem[rd_ptr];

endmodule

//--- hw/trace_fsm.sv
// capture window FSM
`timescale 1ns/10ps

module trace_fsm
    import trace_state_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         stop,
    input  logic         retire,
    input  logic         rd,
    input  logic         full,
    input  logic         empty,
    output logic         push,
    output logic         pop,
    output logic         rec_clear,
    output logic         rec_valid,
    output trace_state_e state
);

    trace_state_e next_state;

    //////////////////////////////////////////////////
    // strobe gating
    //////////////////////////////////////////////////

    // retires only reach the buffer inside the window
    assign push      = (state == st_capture) && retire;
    // reads only pop during readout, a read on empty does nothing
    assign pop       = (state == st_readout) && rd && !empty;
    // count restarts as the window opens
    assign rec_clear = (state == st_idle) && start;
    assign rec_valid = (state == st_readout) && !empty;

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_capture;
                end
            end
            st_capture: begin
                // full is already high on the filling push
                if (stop || full) begin
                    next_state = st_readout;
                end
            end
            st_readout: begin
                // drained, also covers a window that caught nothing
                if (empty) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- hw/trace_top.sv
// pipeline trace unit
`timescale 1ns/10ps

module trace_top
    import trace_cfg_pkg::*;
    import trace_state_pkg::*;
#(
    parameter int STAMP_DEPTH = DEF_STAMP_DEPTH,
    parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         fetch,
    input  instr_t       instr,
    input  logic         stall,
    input  logic         flush,
    input  logic         start,
    input  logic         stop,
    input  logic         rd,
    output logic         rec_valid,
    output seq_id_t      rec_id,
    output instr_t       rec_instr,
    output cycle_t       rec_fetch_cycle,
    output cycle_t       rec_retire_cycle,
    output rec_count_t   rec_count,
    output trace_state_e state
);

    cycle_t  now;
    logic    accept;
    seq_id_t accept_id;
    logic    retire;
    seq_id_t retire_id;
    // stamp read at write-back
    cycle_t  wb_fetch_cycle;
    instr_t  wb_instr;
    logic    push;
    logic    pop;
    logic    full;
    logic    empty;
    logic    rec_clear;

    cycle_counter i_cycle_counter (
        .clk       (clk),
        .rst       (rst),
        .rec_push  (push),
        .rec_clear (rec_clear),
        .now       (now),
        .rec_count (rec_count)
    );

    stage_tracker i_stage_tracker (
        .clk       (clk),
        .rst       (rst),
        .fetch     (fetch),
        .stall     (stall),
        .flush     (flush),
        .accept    (accept),
        .accept_id (accept_id),
        .retire    (retire),
        .retire_id (retire_id)
    );

    // stamped with now on acceptance
    stamp_store #(
        .STAMP_DEPTH (STAMP_DEPTH)
    ) i_stamp_store (
        .clk      (clk),
        .wr       (accept),
        .wr_id    (accept_id),
        .wr_cycle (now),
        .wr_instr (instr),
        .rd_id    (retire_id),
        .rd_cycle (wb_fetch_cycle),
        .rd_instr (wb_instr)
    );

    // record is write-back id, stored stamp and instr, retire stamp
    trace_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_trace_fifo (
        .clk               (clk),
        .rst               (rst),
        .push              (push),
        .push_id           (retire_id),
        .push_instr        (wb_instr),
        .push_fetch_cycle  (wb_fetch_cycle),
        .push_retire_cycle (now),
        .pop               (pop),
        .empty             (empty),
        .full              (full),
        .head_id           (rec_id),
        .head_instr        (rec_instr),
        .head_fetch_cycle  (rec_fetch_cycle),
        .head_retire_cycle (rec_retire_cycle)
    );

    trace_fsm i_trace_fsm (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .stop      (stop),
        .retire    (retire),
        .rd        (rd),
        .full      (full),
        .empty     (empty),
        .push      (push),
        .pop       (pop),
        .rec_clear (rec_clear),
        .rec_valid (rec_valid),
        .state     (state)
    );

endmodule

//--- test/tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    // free-running clock, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset seen on RESET_CYCLES rising edges, released just after the last
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- test/tb_trace_top.sv
// trace unit testbench
`timescale 1ns/10ps

module tb_trace_top
    import trace_cfg_pkg::*;
    import trace_state_pkg::*;
();

    // small buffer so one window fills quickly
    localparam int    FIFO_DEPTH = 8;
    localparam string STIM_FILE  = "test/trace_stim.txt";

    // one D line of the stim file
    typedef struct packed {
        logic         fetch;
        instr_t       instr;
        logic         stall;
        logic         flush;
        logic         start;
        logic         stop;
        logic         rd;
        trace_state_e exp_state;
        rec_count_t   exp_count;
        logic         exp_valid;
    } drive_t;

    // one E line, a retire record in readout order
    typedef struct packed {
        seq_id_t id;
        instr_t  instr;
        cycle_t  fetch_cycle;
        cycle_t  retire_cycle;
    } record_t;

    logic         clk;
    logic         rst;
    logic         fetch;
    instr_t       instr;
    logic         stall;
    logic         flush;
    logic         start;
    logic         stop;
    logic         rd;
    logic         rec_valid;
    seq_id_t      rec_id;
    instr_t       rec_instr;
    cycle_t       rec_fetch_cycle;
    cycle_t       rec_retire_cycle;
    rec_count_t   rec_count;
    trace_state_e state;

    drive_t  drives [$];
    record_t expected [$];
    int      cycles      = 0;
    int      cycle_limit = 0;

    tb_clk_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    trace_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_trace_top (
        .clk              (clk),
        .rst              (rst),
        .fetch            (fetch),
        .instr            (instr),
        .stall            (stall),
        .flush            (flush),
        .start            (start),
        .stop             (stop),
        .rd               (rd),
        .rec_valid        (rec_valid),
        .rec_id           (rec_id),
        .rec_instr        (rec_instr),
        .rec_fetch_cycle  (rec_fetch_cycle),
        .rec_retire_cycle (rec_retire_cycle),
        .rec_count        (rec_count),
        .state            (state)
    );

    //////////////////////////////////////////////////
    // failure and compare tasks
    //////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_record(input seq_id_t exp_id, input instr_t exp_instr,
                                input cycle_t exp_fetch, input cycle_t exp_retire);
        if (rec_id !== exp_id) begin
            abort_run($sformatf("** Error at %0t: rec_id expected 0x%0h, got 0x%0h",
                                $time, exp_id, rec_id));
        end
        if (rec_instr !== exp_instr) begin
            abort_run($sformatf("** Error at %0t: rec_instr expected 0x%0h, got 0x%0h",
                                $time, exp_instr, rec_instr));
        end
        if (rec_fetch_cycle !== exp_fetch) begin
            abort_run($sformatf("** Error at %0t: rec_fetch_cycle expected %0d, got %0d",
                                $time, exp_fetch, rec_fetch_cycle));
        end
        if (rec_retire_cycle !== exp_retire) begin
            abort_run($sformatf("** Error at %0t: rec_retire_cycle expected %0d, got %0d",
                                $time, exp_retire, rec_retire_cycle));
        end
    endtask

    task automatic check_state(input trace_state_e exp);
        if (state !== exp) begin
            abort_run($sformatf("** Error at %0t: state expected %s, got %s",
                                $time, exp.name(), state.name()));
        end
    endtask

    task automatic check_count(input rec_count_t exp);
        if (rec_count !== exp) begin
            abort_run($sformatf("** Error at %0t: rec_count expected %0d, got %0d",
                                $time, exp, rec_count));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: %s expected %b, got %b",
                                $time, name, exp, got));
        end
    endtask

    //////////////////////////////////////////////////
    // stim file reader
    //////////////////////////////////////////////////

    task automatic load_stim();
        int         fd;
        int         n;
        string      kind;
        string      rest;
        drive_t     d;
        record_t    e;
        logic       fetch_v;
        instr_t     instr_v;
        logic       stall_v;
        logic       flush_v;
        logic       start_v;
        logic       stop_v;
        logic       rd_v;
        logic [1:0] state_v;
        rec_count_t count_v;
        logic       valid_v;
        seq_id_t    id_v;
        cycle_t     fc_v;
        cycle_t     rc_v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("cannot open the stimulus file %s", STIM_FILE));
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                break;
            end
            if (kind == "D") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", fetch_v, instr_v,
                            stall_v, flush_v, start_v, stop_v, rd_v, state_v,
                            count_v, valid_v);
                if (n != 10) begin
                    abort_run("a D line in the stimulus file is malformed");
                end
                d.fetch     = fetch_v;
                d.instr     = instr_v;
                d.stall     = stall_v;
                d.flush     = flush_v;
                d.start     = start_v;
                d.stop      = stop_v;
                d.rd        = rd_v;
                d.exp_state = trace_state_e'(state_v);
                d.exp_count = count_v;
                d.exp_valid = valid_v;
                drives.push_back(d);
            end else if (kind == "E") begin
                n = $fscanf(fd, "%h %h %h %h", id_v, instr_v, fc_v, rc_v);
                if (n != 4) begin
                    abort_run("an E line in the stimulus file is malformed");
                end
                e.id           = id_v;
                e.instr        = instr_v;
                e.fetch_cycle  = fc_v;
                e.retire_cycle = rc_v;
                expected.push_back(e);
            end else if (kind == "#") begin
                // comment line, skip the rest
                n = $fgets(rest, fd);
            end else begin
                abort_run($sformatf("unknown line kind %s in the stimulus file", kind));
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_drive(input drive_t d);
        fetch = d.fetch;
        instr = d.instr;
        stall = d.stall;
        flush = d.flush;
        start = d.start;
        stop  = d.stop;
        rd    = d.rd;
    endtask

    //////////////////////////////////////////////////
    // timeout
    //////////////////////////////////////////////////

    // limit is known once the D lines are loaded
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            abort_run($sformatf("run timed out after %0d cycles", cycles));
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        drive_t  d;
        record_t e;
        fetch = 1'b0;
        instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        start = 1'b0;
        stop  = 1'b0;
        rd    = 1'b0;
        load_stim();
        cycle_limit = drives.size() + 50;

        // line 0 lands in the first cycle after reset, stamp 0
        @(negedge rst);
        foreach (drives[i]) begin
            d = drives[i];
            apply_drive(d);
            // outputs settled mid cycle
            @(negedge clk);
            check_state(d.exp_state);
            check_count(d.exp_count);
            check_flag("rec_valid", d.exp_valid, rec_valid);
            if (d.rd && rec_valid) begin
                if (expected.size() == 0) begin
                    abort_run("a record was read out with no expected record left");
                end else begin
                    e = expected.pop_front();
                    check_record(e.id, e.instr, e.fetch_cycle, e.retire_cycle);
                end
            end
            @(posedge clk);
            #1;
        end

        if (expected.size() != 0) begin
            $display("%0d expected records were never read out", expected.size());
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- trace_top.f
hw/trace_cfg_pkg.sv
hw/trace_state_pkg.sv
hw/cycle_counter.sv
hw/stage_tracker.sv
hw/stamp_store.sv
hw/trace_fifo.sv
hw/trace_fsm.sv
hw/trace_top.sv
test/tb_clk_gen.sv
test/tb_trace_top.sv

//--- Makefile
# Verilator build and run of the trace unit testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP       = tb_trace_top
FILELIST  = trace_top.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_TEXT = RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# the simulator status is ignored here, the log search decides
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/trace_stim.txt
# D fetch instr stall flush start stop rd | expected state count rec_valid, hex, one per cycle
# E id instr fetch_cycle retire_cycle, hex, readout order, fifo depth 8
D 0 00000000 0 0 1 0 0 0 00 0
D 1 a5c30001 0 0 0 0 0 1 00 0
D 1 a5c30002 0 0 0 0 0 1 00 0
D 1 a5c30003 0 0 0 0 0 1 00 0
D 1 a5c30004 0 0 0 0 0 1 00 0
D 1 a5c30005 0 0 0 0 0 1 00 0
D 1 a5c30006 1 0 0 0 0 1 00 0
D 0 00000000 1 0 0 0 0 1 01 0
D 1 a5c30008 0 0 0 0 0 1 02 0
D 1 a5c30009 0 0 0 0 0 1 03 0
D 1 a5c3000a 0 0 0 0 0 1 03 0
D 1 a5c3000b 0 0 0 0 0 1 03 0
D 0 00000000 0 1 0 0 0 1 04 0
D 1 a5c3000d 0 0 0 0 0 1 05 0
D 1 a5c3000e 0 0 0 0 0 1 06 0
D 0 00000000 0 0 0 0 0 1 07 0
D 0 00000000 0 0 0 0 0 1 07 0
D 0 00000000 0 0 0 0 0 1 07 0
D 0 00000000 0 0 0 0 0 1 07 0
D 0 00000000 0 0 0 0 1 2 08 1
D 0 00000000 0 0 0 0 1 2 08 1
D 0 00000000 0 0 0 0 1 2 08 1
D 0 00000000 0 0 0 0 1 2 08 1
D 0 00000000 0 0 0 0 1 2 08 1
D 0 00000000 0 0 0 0 1 2 08 1
D 0 00000000 0 0 0 0 1 2 08 1
D 0 00000000 0 0 0 0 1 2 08 1
D 0 00000000 0 0 0 0 1 2 08 0
D 0 00000000 0 0 0 0 1 0 08 0
D 0 00000000 0 0 1 0 0 0 08 0
D 0 00000000 0 0 0 1 0 1 00 0
D 0 00000000 0 0 0 0 0 2 00 0
D 0 00000000 0 0 0 0 0 0 00 0
E 00 a5c30001 0001 0006
E 01 a5c30002 0002 0007
E 02 a5c30003 0003 0008
E 03 a5c30004 0004 000b
E 04 a5c30005 0005 000c
E 05 a5c30008 0008 000d
E 06 a5c30009 0009 000e
E 09 a5c3000d 000d 0012
